/* hw/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // device codes, address bits 15:12
    localparam logic [3:0] DEV_MEM    = 4'h0;
    localparam logic [3:0] DEV_ONCHIP = 4'h1;
    localparam logic [3:0] DEV_IO     = 4'h2;

    // sub-device codes, address bits 11:8
    localparam logic [3:0] S_DEV_FP   = 4'h0;   // under DEV_ONCHIP

    localparam logic [3:0] S_DEV_HEX  = 4'h0;   // under DEV_IO
    localparam logic [3:0] S_DEV_SW   = 4'h1;
    localparam logic [3:0] S_DEV_LEDR = 4'h2;
    localparam logic [3:0] S_DEV_KEY  = 4'h3;
    localparam logic [3:0] S_DEV_IR   = 4'h4;
    localparam logic [3:0] S_DEV_PS2  = 4'h5;

    localparam int HEX_DIGITS = 6;

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] wdata;
        logic        read;
        logic        write;
    } bus_req_t;

    // request after device decode, strobes already qualified
    typedef struct packed {
        logic [11:0] offset;
        logic [15:0] wdata;
        logic        read;
        logic        write;
    } dev_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        done;
    } bus_rsp_t;

    typedef struct packed {
        logic [HEX_DIGITS-1:0][6:0] hex;
        logic [9:0]                 ledr;
        logic                       irda_txd;
    } board_out_t;

endpackage

`default_nettype wire

/* hw/bus_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_decoder import bus_pkg::*; (
    input  logic     Clock,
    input  logic     Reset,
    input  bus_req_t bus_req,
    output dev_req_t mem_req,
    output dev_req_t fp_req,
    output dev_req_t io_req,
    output dev_req_t ps2_req,
    input  bus_rsp_t mem_rsp,
    input  bus_rsp_t fp_rsp,
    input  bus_rsp_t io_rsp,
    input  bus_rsp_t ps2_rsp,
    output bus_rsp_t bus_rsp
);

    logic [3:0] device;
    logic [3:0] sub_device;
    logic       strobe;
    logic       mem_sel;
    logic       fp_sel;
    logic       io_sel;
    logic       ps2_sel;
    logic       mem_done;
    bus_rsp_t   sel_rsp;

    // pass the request on with strobes gated by the select
    function automatic dev_req_t qualify(input bus_req_t r, input logic sel);
        dev_req_t d;
        d.offset = r.addr[11:0];
        d.wdata  = r.wdata;
        d.read   = r.read & sel;
        d.write  = r.write & sel;
        return d;
    endfunction

    assign device     = bus_req.addr[15:12];
    assign sub_device = bus_req.addr[11:8];
    assign strobe     = bus_req.read | bus_req.write;

    assign mem_sel = (device == DEV_MEM);
    assign fp_sel  = (device == DEV_ONCHIP) && (sub_device == S_DEV_FP);
    assign ps2_sel = (device == DEV_IO) && (sub_device == S_DEV_PS2);
    assign io_sel  = (device == DEV_IO) && (sub_device != S_DEV_PS2);

    assign mem_req = qualify(bus_req, mem_sel);
    assign fp_req  = qualify(bus_req, fp_sel);
    assign io_req  = qualify(bus_req, io_sel);
    assign ps2_req = qualify(bus_req, ps2_sel);

    // toggles while the strobe is held, so done lasts one cycle
    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            mem_done <= 1'b0;
        end else if (mem_sel && strobe) begin
            mem_done <= ~mem_done;
        end else begin
            mem_done <= 1'b0;
        end
    end

    always_comb begin
        sel_rsp = '{rdata: 16'h0000, done: 1'b1};   // unmapped default
        case (device)
            DEV_MEM:    sel_rsp = '{rdata: mem_rsp.rdata, done: mem_done};
            DEV_ONCHIP: if (fp_sel) sel_rsp = fp_rsp;
            DEV_IO:     sel_rsp = ps2_sel ? ps2_rsp : io_rsp;
            default:    ;
        endcase
    end

    // nothing completes while in reset
    assign bus_rsp = '{rdata: sel_rsp.rdata, done: sel_rsp.done & strobe & ~Reset};

endmodule

`default_nettype wire

/* hw/data_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module data_mem import bus_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic     Clock,
    input  dev_req_t req,
    output bus_rsp_t rsp
);

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    logic [15:0]              mem [DEPTH];
    logic [MEM_ADDR_BITS-1:0] index;
    logic [15:0]              rdata_q;

    assign index = req.offset[MEM_ADDR_BITS-1:0];   // high offset bits alias

    always_ff @(posedge Clock) begin
        if (req.write) begin
            mem[index] <= req.wdata;
        end
        rdata_q <= mem[index];   // read every edge, ready with the decoder's done
    end

    // completion is sequenced by the decoder
    assign rsp = '{rdata: rdata_q, done: 1'b1};

endmodule

`default_nettype wire

/* hw/io_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module io_regs import bus_pkg::*; (
    input  logic       Clock,
    input  logic       Reset,
    input  dev_req_t   req,
    input  logic [9:0] sw,
    input  logic [3:0] key,
    input  logic       irda_rxd,
    output board_out_t board,
    output bus_rsp_t   rsp
);

    logic [3:0]                 sub_device;
    logic [2:0]                 digit;
    logic                       digit_ok;
    logic [HEX_DIGITS-1:0][6:0] hex_q;
    logic [9:0]                 ledr_q;
    logic                       ir_tx_q;
    logic                       ir_rx_q;
    logic [15:0]                rdata;

    assign sub_device = req.offset[11:8];
    assign digit      = req.offset[2:0];
    assign digit_ok   = (digit < 3'(HEX_DIGITS));   // indices 6 and 7 are holes

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            hex_q   <= '0;
            ledr_q  <= '0;
            ir_tx_q <= 1'b0;
            ir_rx_q <= 1'b0;
        end else begin
            if (req.write) begin
                case (sub_device)
                    S_DEV_HEX:  if (digit_ok) hex_q[digit] <= req.wdata[6:0];
                    S_DEV_LEDR: ledr_q <= req.wdata[9:0];
                    S_DEV_IR:   ir_tx_q <= req.wdata[0];
                    default:    ;   // inputs are read only
                endcase
            end
            ir_rx_q <= irda_rxd;   // sampled every cycle
        end
    end

    always_comb begin
        rdata = 16'h0000;
        case (sub_device)
            S_DEV_HEX:  if (digit_ok) rdata = {9'h000, hex_q[digit]};
            S_DEV_SW:   rdata = {6'h00, sw};
            S_DEV_LEDR: rdata = {6'h00, ledr_q};
            S_DEV_KEY:  rdata = {12'h000, key};
            S_DEV_IR:   rdata = {15'h0000, ir_rx_q};
            default:    rdata = 16'h0000;
        endcase
    end

    // all I/O registers answer in the same cycle
    assign rsp = '{rdata: rdata, done: 1'b1};

    assign board = '{hex: hex_q, ledr: ledr_q, irda_txd: ir_tx_q};

endmodule

`default_nettype wire

/* hw/ps2_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2_receiver import bus_pkg::*; (
    input  logic     Clock,
    input  logic     Reset,
    input  dev_req_t req,
    input  logic     ps2_clk,
    input  logic     ps2_data,
    output bus_rsp_t rsp
);

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic       bit_in;
    logic [3:0] bit_cnt;    // 0 idle, 1..8 data, 9 parity, 10 stop
    logic [7:0] shift_q;
    logic       parity_q;
    logic       frame_ok;
    logic [7:0] byte_q;
    logic       valid_q;
    logic       error_q;
    logic       status_rd;

    assign clk_fall  = clk_prev & ~clk_sync[1];
    assign bit_in    = data_sync[1];
    assign frame_ok  = (^{shift_q, parity_q}) & bit_in;   // odd parity and stop high
    assign status_rd = req.read && (req.offset[7:0] == 8'h00);

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            clk_sync  <= 2'b11;   // lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
            bit_cnt   <= 4'd0;
            byte_q    <= 8'h00;
            valid_q   <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
            if (status_rd) begin
                valid_q <= 1'b0;   // cleared once the CPU has seen them
                error_q <= 1'b0;
            end
            if (clk_fall) begin
                if (bit_cnt == 4'd0) begin
                    if (!bit_in) bit_cnt <= 4'd1;   // start bit
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt <= 4'd0;
                    if (frame_ok) begin
                        byte_q  <= shift_q;
                        valid_q <= 1'b1;
                    end else begin
                        error_q <= 1'b1;   // old byte stays
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (clk_fall && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_q <= {bit_in, shift_q[7:1]};   // LSB first
        end
        if (clk_fall && bit_cnt == 4'd9) begin
            parity_q <= bit_in;
        end
    end

    assign rsp.rdata = (req.offset[7:0] == 8'h00) ? {6'h00, error_q, valid_q, byte_q}
                                                  : 16'h0000;
    assign rsp.done  = 1'b1;

endmodule

`default_nettype wire

/* hw/fp_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mult import bus_pkg::*; #(
    parameter int FP_LATENCY = 3
) (
    input  logic     Clock,
    input  logic     Reset,
    input  dev_req_t req,
    output bus_rsp_t rsp
);

    logic [15:0]                 opa_q;
    logic [15:0]                 opb_q;
    logic [15:0]                 prod_q;
    logic [FP_LATENCY-1:0]       vld_pipe;
    logic [FP_LATENCY-1:0][15:0] res_pipe;
    logic                        busy;
    logic                        wr_a;
    logic                        wr_b;
    logic [15:0]                 prod_now;

    // half-precision multiply, no NaN or denormal handling
    function automatic logic [15:0] half_mul(input logic [15:0] a, input logic [15:0] b);
        logic              sign;
        logic [21:0]       mant;
        logic [9:0]        frac;
        logic              shift;
        logic signed [7:0] exp_sum;
        sign  = a[15] ^ b[15];
        mant  = {1'b1, a[9:0]} * {1'b1, b[9:0]};
        shift = mant[21];
        frac  = shift ? mant[20:11] : mant[19:10];   // truncated
        exp_sum = $signed({3'b000, a[14:10]}) + $signed({3'b000, b[14:10]})
                  + $signed({7'h00, shift}) - 8'sd15;
        if (a[14:10] == 5'd0 || b[14:10] == 5'd0) begin
            return {sign, 15'h0000};
        end
        if (exp_sum >= 8'sd31) begin
            return {sign, 5'h1f, 10'h000};   // saturate to infinity
        end
        if (exp_sum <= 8'sd0) begin
            return {sign, 15'h0000};   // underflow
        end
        return {sign, exp_sum[4:0], frac};
    endfunction

    assign busy = |vld_pipe;
    assign wr_a = req.write && !busy && (req.offset[7:0] == 8'h00);
    assign wr_b = req.write && !busy && (req.offset[7:0] == 8'h01);   // starts a multiply
    assign prod_now = half_mul(opa_q, req.wdata);

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= wr_b;
            for (int i = 1; i < FP_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (wr_a) opa_q <= req.wdata;
        if (wr_b) opb_q <= req.wdata;
        res_pipe[0] <= prod_now;
        for (int i = 1; i < FP_LATENCY; i++) begin
            res_pipe[i] <= res_pipe[i-1];
        end
        if (vld_pipe[FP_LATENCY-1]) begin
            prod_q <= res_pipe[FP_LATENCY-1];   // product visible once wait drops
        end
    end

    always_comb begin
        case (req.offset[7:0])
            8'h00:   rsp.rdata = opa_q;
            8'h01:   rsp.rdata = opb_q;
            8'h02:   rsp.rdata = prod_q;
            default: rsp.rdata = 16'h0000;
        endcase
    end

    assign rsp.done = ~busy;   // wait stalls the bus

endmodule

`default_nettype wire

/* hw/system_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module system_bus import bus_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10,
    parameter int FP_LATENCY    = 3
) (
    input  logic       Clock,
    input  logic       Reset,
    input  bus_req_t   bus_req,
    output bus_rsp_t   bus_rsp,
    input  logic [9:0] SW,
    input  logic [3:0] KEY,
    input  logic       IRDA_RXD,
    input  logic       PS2_CLK,
    input  logic       PS2_DATA,
    output board_out_t board
);

    dev_req_t mem_req;
    dev_req_t fp_req;
    dev_req_t io_req;
    dev_req_t ps2_req;
    bus_rsp_t mem_rsp;
    bus_rsp_t fp_rsp;
    bus_rsp_t io_rsp;
    bus_rsp_t ps2_rsp;

    bus_decoder u_decoder (
        .Clock   (Clock),
        .Reset   (Reset),
        .bus_req (bus_req),
        .mem_req (mem_req),
        .fp_req  (fp_req),
        .io_req  (io_req),
        .ps2_req (ps2_req),
        .mem_rsp (mem_rsp),
        .fp_rsp  (fp_rsp),
        .io_rsp  (io_rsp),
        .ps2_rsp (ps2_rsp),
        .bus_rsp (bus_rsp)
    );

    data_mem #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_data_mem (
        .Clock (Clock),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    fp_mult #(.FP_LATENCY(FP_LATENCY)) u_fp_mult (
        .Clock (Clock),
        .Reset (Reset),
        .req   (fp_req),
        .rsp   (fp_rsp)
    );

    io_regs u_io_regs (
        .Clock    (Clock),
        .Reset    (Reset),
        .req      (io_req),
        .sw       (SW),
        .key      (KEY),
        .irda_rxd (IRDA_RXD),
        .board    (board),
        .rsp      (io_rsp)
    );

    ps2_receiver u_ps2 (
        .Clock    (Clock),
        .Reset    (Reset),
        .req      (ps2_req),
        .ps2_clk  (PS2_CLK),
        .ps2_data (PS2_DATA),
        .rsp      (ps2_rsp)
    );

endmodule

`default_nettype wire

/* verif/system_bus_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module system_bus_chk import bus_pkg::*; #(
    parameter int FP_LATENCY = 3
) (
    input logic     Clock,
    input logic     Reset,
    input bus_rsp_t bus_rsp,
    input dev_req_t fp_req,
    input bus_rsp_t fp_rsp,
    input dev_req_t mem_req
);

    logic fp_start;
    logic mem_strobe;
    int   fp_left;
    int   reset_fails = 0;
    int   mem_fails = 0;
    int   fp_fails = 0;
    int   fail_total;

    // write to operand B accepted while the multiplier is idle
    assign fp_start = fp_req.write && (fp_req.offset[7:0] == 8'h01) && fp_rsp.done;

    assign mem_strobe = mem_req.read || mem_req.write;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            fp_left <= 0;
        end else if (fp_start) begin
            fp_left <= FP_LATENCY;
        end else if (fp_left != 0) begin
            fp_left <= fp_left - 1;
        end
    end

    assign fail_total = reset_fails + mem_fails + fp_fails;   // read by the testbench

    reset_done_low: assert property (@(posedge Clock) Reset |-> !bus_rsp.done)
        else begin
            $error("bus done high during reset");
            reset_fails++;
        end

    // one done pulse, in the second cycle of a memory access
    mem_done_single: assert property (@(posedge Clock) disable iff (Reset)
        $rose(mem_strobe) |-> !bus_rsp.done ##1 bus_rsp.done ##1 !bus_rsp.done)
        else begin
            $error("memory done not a single pulse in the second cycle of an access");
            mem_fails++;
        end

    fp_wait_held: assert property (@(posedge Clock) disable iff (Reset)
        (fp_left != 0) |-> !fp_rsp.done)
        else begin
            $error("multiplier done before its latency ran out");
            fp_fails++;
        end

endmodule

`default_nettype wire

/* verif/tb_system_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_system_bus import bus_pkg::*; ();

    localparam int MEM_ADDR_BITS  = 10;
    localparam int FP_LATENCY     = 3;
    localparam int ACCESS_LIMIT   = 64;      // cycles one access may take
    localparam int PS2_HALF       = 4;       // system clocks per PS/2 half period
    localparam int TIMEOUT_CYCLES = 20000;   // well over the summed test lengths

    logic       Clock;
    logic       Reset;
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic [9:0] SW;
    logic [3:0] KEY;
    logic       IRDA_RXD;
    logic       PS2_CLK;
    logic       PS2_DATA;
    board_out_t board;

    integer      seed;
    int          errors;
    int          rsp_errors;
    int          err_mark;
    int          tests_run;
    int          tests_bad;
    int          cycle_count;
    int          total;
    string       cur_test;
    logic [15:0] exp_q[$];                          // expected read data, in order
    logic [15:0] mem_model [1 << MEM_ADDR_BITS];
    board_out_t  exp_board;

    system_bus #(.MEM_ADDR_BITS(MEM_ADDR_BITS), .FP_LATENCY(FP_LATENCY)) dut (
        .Clock    (Clock),
        .Reset    (Reset),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .SW       (SW),
        .KEY      (KEY),
        .IRDA_RXD (IRDA_RXD),
        .PS2_CLK  (PS2_CLK),
        .PS2_DATA (PS2_DATA),
        .board    (board)
    );

    // latency matches FP_LATENCY above
    bind bus_decoder system_bus_chk #(.FP_LATENCY(3)) u_chk (
        .Clock   (Clock),
        .Reset   (Reset),
        .bus_rsp (bus_rsp),
        .fp_req  (fp_req),
        .fp_rsp  (fp_rsp),
        .mem_req (mem_req)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // half-precision product: truncated, saturating, no denormals
    function automatic logic [15:0] ref_fp_mult(input logic [15:0] a, input logic [15:0] b);
        logic        sign;
        int          ea;
        int          eb;
        int          e_res;
        logic [21:0] prod;
        logic [9:0]  frac;
        sign = a[15] ^ b[15];
        ea   = int'(a[14:10]);
        eb   = int'(b[14:10]);
        if (ea == 0 || eb == 0) return {sign, 15'h0000};
        prod = 22'({1'b1, a[9:0]}) * 22'({1'b1, b[9:0]});
        if (prod[21]) begin
            e_res = ea + eb - 14;
            frac  = prod[20:11];
        end else begin
            e_res = ea + eb - 15;
            frac  = prod[19:10];
        end
        if (e_res >= 31) return {sign, 5'h1f, 10'h000};
        if (e_res <= 0) return {sign, 15'h0000};
        return {sign, e_res[4:0], frac};
    endfunction

    task automatic check_rsp(input string name, input bus_rsp_t act, input logic [15:0] exp,
                             inout int err);
        if (act.done !== 1'b1 || act.rdata !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h (done %b)",
                     name, exp, act.rdata, act.done);
            err++;
        end
    endtask

    task automatic check_board(input string name, input board_out_t act, input board_out_t exp,
                               inout int err);
        if (act !== exp) begin
            $display("Mismatch in %s: expected board %h, actual %h", name, exp, act);
            err++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act, inout int err);
        if (act != exp) begin
            $display("Mismatch in %s: expected %0d cycles to done, actual %0d", name, exp, act);
            err++;
        end
    endtask

    // every completed read is compared against the queue
    always @(negedge Clock) begin
        if (bus_req.read && bus_rsp.done) begin
            if (exp_q.size() == 0) begin
                $display("read of %h finished with no expected value queued", bus_req.addr);
                rsp_errors++;
            end else begin
                check_rsp(cur_test, bus_rsp, exp_q.pop_front(), rsp_errors);
            end
        end
    end

    // hold the strobe until done, then drop it for at least one cycle
    task automatic bus_access(input logic [15:0] addr, input logic [15:0] wdata,
                              input logic is_write, output int cycles);
        cycles = 0;
        @(posedge Clock);
        bus_req.addr  <= addr;
        bus_req.wdata <= wdata;
        bus_req.read  <= ~is_write;
        bus_req.write <= is_write;
        do begin
            @(negedge Clock);
            cycles++;
        end while (!bus_rsp.done && cycles < ACCESS_LIMIT);
        if (!bus_rsp.done) begin
            $display("%s: no done from address %h within %0d cycles", cur_test, addr,
                     ACCESS_LIMIT);
            errors++;
            if (!is_write) void'(exp_q.pop_front());
        end
        @(posedge Clock);
        bus_req.read  <= 1'b0;
        bus_req.write <= 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [15:0] wdata,
                             output int cycles);
        bus_access(addr, wdata, 1'b1, cycles);
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [15:0] exp, output int cycles);
        exp_q.push_back(exp);
        bus_access(addr, 16'h0000, 1'b0, cycles);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors + rsp_errors;
    endtask

    task automatic finish_test();
        int bad;
        bad = errors + rsp_errors - err_mark;
        tests_run++;
        if (bad == 0) begin
            $display("%-10s ok", cur_test);
        end else begin
            $display("%-10s FAIL, %0d errors", cur_test, bad);
            tests_bad++;
        end
    endtask

    task automatic test_memory();
        logic [15:0] addrs [64];
        logic [15:0] data;
        int          cycles;
        start_test("memory");
        for (int i = 0; i < 64; i++) begin
            addrs[i] = {4'h0, 12'($random(seed))};
            data     = 16'($random(seed));
            mem_model[addrs[i][MEM_ADDR_BITS-1:0]] = data;   // high offset bits alias
            bus_write(addrs[i], data, cycles);
            check_cycles(cur_test, 2, cycles, errors);
        end
        for (int i = 0; i < 64; i++) begin
            bus_read(addrs[i], mem_model[addrs[i][MEM_ADDR_BITS-1:0]], cycles);
            check_cycles(cur_test, 2, cycles, errors);
        end
        finish_test();
    endtask

    task automatic test_hex_ledr();
        logic [15:0] data;
        int          cycles;
        start_test("hex_ledr");
        @(negedge Clock);
        check_board(cur_test, board, exp_board, errors);   // all zero out of reset
        for (int d = 0; d < HEX_DIGITS; d++) begin
            data = 16'($random(seed));
            exp_board.hex[d] = data[6:0];
            bus_write(16'h2000 | 16'(d), data, cycles);
        end
        data = 16'($random(seed));
        exp_board.ledr = data[9:0];
        bus_write(16'h2200, data, cycles);
        @(negedge Clock);
        check_board(cur_test, board, exp_board, errors);
        bus_write(16'h2006, 16'($random(seed)), cycles);   // no digit 6
        @(negedge Clock);
        check_board(cur_test, board, exp_board, errors);
        for (int d = 0; d < HEX_DIGITS; d++) begin
            bus_read(16'h2000 | 16'(d), {9'h000, exp_board.hex[d]}, cycles);
        end
        bus_read(16'h2200, {6'h00, exp_board.ledr}, cycles);
        bus_read(16'h2006, 16'h0000, cycles);
        bus_read(16'h2007, 16'h0000, cycles);
        finish_test();
    endtask

    task automatic test_inputs_ir();
        logic [9:0] sw_val;
        logic [3:0] key_val;
        logic [2:0] ir_bits;
        int         cycles;
        start_test("inputs_ir");
        for (int i = 0; i < 8; i++) begin
            sw_val  = 10'($random(seed));
            key_val = 4'($random(seed));
            @(posedge Clock);
            SW  <= sw_val;
            KEY <= key_val;
            bus_read(16'h2100, {6'h00, sw_val}, cycles);
            bus_read(16'h2300, {12'h000, key_val}, cycles);
        end
        ir_bits = 3'b101;
        for (int i = 0; i < 3; i++) begin
            @(posedge Clock);
            IRDA_RXD <= ir_bits[i];
            @(posedge Clock);   // settle through the input register
            bus_read(16'h2400, {15'h0000, ir_bits[i]}, cycles);
        end
        for (int i = 0; i < 2; i++) begin
            exp_board.irda_txd = ~ir_bits[i];
            bus_write(16'h2400, {15'h0000, ~ir_bits[i]}, cycles);
            @(negedge Clock);
            check_board(cur_test, board, exp_board, errors);
        end
        finish_test();
    endtask

    // start, eight data bits LSB first, odd parity, stop
    task automatic ps2_send(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^data ^ bad_parity;
        frame  = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge Clock);
            PS2_DATA <= frame[i];
            repeat (PS2_HALF) @(posedge Clock);
            PS2_CLK <= 1'b0;
            repeat (PS2_HALF) @(posedge Clock);
            PS2_CLK <= 1'b1;
        end
        repeat (PS2_HALF) @(posedge Clock);   // let the synchronizer catch up
    endtask

    task automatic test_ps2();
        logic [7:0] data;
        logic [7:0] last;
        int         cycles;
        start_test("ps2");
        last = 8'h00;
        for (int i = 0; i < 3; i++) begin
            data = 8'($random(seed));
            ps2_send(data, 1'b0);
            bus_read(16'h2500, {6'h00, 2'b01, data}, cycles);
            bus_read(16'h2500, {8'h00, data}, cycles);   // valid gone after first read
            last = data;
        end
        ps2_send(8'($random(seed)), 1'b1);
        bus_read(16'h2500, {6'h00, 2'b10, last}, cycles);   // old byte kept
        bus_read(16'h2500, {8'h00, last}, cycles);
        finish_test();
    endtask

    task automatic fp_check(input logic [15:0] a, input logic [15:0] b);
        int cycles;
        bus_write(16'h1000, a, cycles);
        bus_write(16'h1001, b, cycles);
        bus_read(16'h1002, ref_fp_mult(a, b), cycles);
        check_cycles(cur_test, FP_LATENCY, cycles, errors);   // stalled by wait
        bus_read(16'h1000, a, cycles);
        bus_read(16'h1001, b, cycles);
        check_cycles(cur_test, 1, cycles, errors);
    endtask

    task automatic test_fp();
        start_test("fp_mult");
        fp_check(16'h3c00, 16'h3c00);   // 1 * 1
        fp_check(16'h4000, 16'h3e00);   // 2 * 1.5
        fp_check(16'h0000, 16'h3c00);   // zero
        fp_check(16'h8001, 16'h3c00);   // denormal in, signed zero out
        fp_check(16'h7800, 16'h7800);   // overflow
        fp_check(16'hf800, 16'h7800);
        fp_check(16'h0400, 16'h0400);   // underflow
        fp_check(16'h0400, 16'h3c00);   // smallest normal survives
        for (int i = 0; i < 50; i++) begin
            fp_check(16'($random(seed)), 16'($random(seed)));
        end
        finish_test();
    endtask

    task automatic test_unmapped();
        int cycles;
        start_test("unmapped");
        for (int dev = 3; dev < 16; dev++) begin
            bus_read({4'(dev), 12'($random(seed))}, 16'h0000, cycles);
            check_cycles(cur_test, 1, cycles, errors);
        end
        finish_test();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge Clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        seed       = 29350;
        errors     = 0;
        rsp_errors = 0;
        tests_run  = 0;
        tests_bad  = 0;
        exp_board  = '0;
        Reset    <= 1'b1;
        // switch read held through reset, it must not complete
        bus_req  <= '{addr: 16'h2100, wdata: 16'h0000, read: 1'b1, write: 1'b0};
        SW       <= '0;
        KEY      <= '0;
        IRDA_RXD <= 1'b0;
        PS2_CLK  <= 1'b1;   // idle high
        PS2_DATA <= 1'b1;
        repeat (4) @(posedge Clock);
        Reset        <= 1'b0;
        bus_req.read <= 1'b0;
        @(posedge Clock);
        test_memory();
        test_hex_ledr();
        test_inputs_ir();
        test_ps2();
        test_fp();
        test_unmapped();
        repeat (2) @(posedge Clock);
        if (exp_q.size() != 0) begin
            $display("%0d expected reads were never answered", exp_q.size());
            errors++;
        end
        total = errors + rsp_errors + dut.u_decoder.u_chk.fail_total;
        $display("tests: %0d run, %0d ok, %0d with errors, %0d assertion failures",
                 tests_run, tests_run - tests_bad, tests_bad, dut.u_decoder.u_chk.fail_total);
        if (total == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/bus_pkg.sv
hw/bus_decoder.sv
hw/data_mem.sv
hw/io_regs.sv
hw/ps2_receiver.sv
hw/fp_mult.sv
hw/system_bus.sv
verif/system_bus_chk.sv
verif/tb_system_bus.sv

/* Makefile */
# Verilator build and run for the system bus testbench

VERILATOR ?= verilator
TOP       ?= tb_system_bus
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
